// ==== Makefile ====
TOP = tb_rng_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== project.f ====
rng_pkg.sv
rng_decode.sv
rng_gen.sv
rng_result.sv
rng_top.sv
tb_rng_top.sv

// ==== rng_decode.sv ====
`timescale 1ns/100ps

module rng_decode (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cmd_valid,
   input  rng_pkg::rng_cmd_t cmd,
   output logic              cmd_ready,
   output logic              cfg_valid,
   output rng_pkg::rng_cfg_t cfg,
   input  logic              cfg_ready,
   output logic              rej_pulse
);

   logic                           op_legal;
   logic                           cmd_ok;
   logic                           cmd_take;
   logic [rng_pkg::rng_data_w-1:0] step;
   rng_pkg::rng_cfg_t              cfg_next;

   // Opcode classification and effective step.
   always_comb begin
      op_legal = 1'b1;
      step     = '0;
      case (cmd.op)
         rng_pkg::op_up: begin
            step = {{(rng_pkg::rng_data_w-1){1'b0}}, 1'b1};
         end
         rng_pkg::op_step: begin
            step = cmd.incr;
         end
         rng_pkg::op_step_neg: begin
            step = -cmd.incr;  // Subtraction as a negated step.
         end
         rng_pkg::op_fill: begin
            step = '0;
         end
         default: begin
            op_legal = 1'b0;
         end
      endcase
   end

   // Empty list is not generated, it is rejected here instead.
   assign cmd_ok = op_legal & (cmd.cnt != '0);

   always_comb begin
      cfg_next      = '0;
      cfg_next.base = cmd.base;
      cfg_next.step = step;
      cfg_next.cnt  = cmd.cnt;
   end

   // Holding register is free when empty or released this cycle.
   assign cmd_ready = ~cfg_valid | cfg_ready;
   assign cmd_take  = cmd_valid & cmd_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg_valid <= 1'b0;
         rej_pulse <= 1'b0;
      end else begin
         rej_pulse <= cmd_take & ~cmd_ok;
         if (cmd_take) begin
            cfg_valid <= cmd_ok;  // Rejected command leaves the slot empty.
         end else if (cfg_ready) begin
            cfg_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_take && cmd_ok) begin
         cfg <= cfg_next;
      end
   end

endmodule

// ==== rng_gen.sv ====
`timescale 1ns/100ps

module rng_gen (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cfg_valid,
   input  rng_pkg::rng_cfg_t cfg,
   output logic              cfg_ready,
   output logic              el_valid,
   output rng_pkg::rng_out_t el,
   input  logic              el_ready
);

   logic                           xfer;
   logic                           last;
   logic                           started;
   logic [rng_pkg::rng_data_w-1:0] cur_val;
   logic [rng_pkg::rng_data_w-1:0] el_data;
   logic [rng_pkg::rng_data_w-1:0] next_val;
   logic [rng_pkg::rng_cnt_w-1:0]  idx;
   logic [rng_pkg::rng_cnt_w-1:0]  last_idx;

   // Element transfer on the output side.
   assign xfer = cfg_valid & el_ready;

   // Count is never zero here, decode rejects it.
   assign last_idx = cfg.cnt - 1'b1;
   assign last     = (idx == last_idx);

   // First element is the base, later ones come from the accumulator.
   assign el_data  = started ? cur_val : cfg.base;
   assign next_val = el_data + cfg.step;  // Wraps modulo 2**rng_data_w.

   assign el_valid  = cfg_valid;
   assign cfg_ready = last & xfer;  // Release the config with its last element.

   always_comb begin
      el      = '0;
      el.data = el_data;
      el.idx  = idx;
      el.eot  = last;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         started <= 1'b0;
         idx     <= '0;
      end else if (xfer && last) begin
         started <= 1'b0;
         idx     <= '0;
      end else if (xfer) begin
         started <= 1'b1;
         idx     <= idx + 1'b1;
      end
   end

   // Accumulator value is ignored until started is set.
   always_ff @(posedge clk) begin
      if (xfer && last) begin
         cur_val <= '0;
      end else if (xfer) begin
         cur_val <= next_val;
      end
   end

endmodule

// ==== rng_pkg.sv ====
package rng_pkg;

   // Datapath widths.
   localparam int rng_data_w = 16;  // Base, increment and output value.
   localparam int rng_cnt_w  = 8;   // Element count and element index.
   localparam int rng_stat_w = 16;  // Completed and rejected command counters.

   // Command opcodes. Codes 4 to 7 are illegal and get rejected by decode.
   typedef enum logic [2:0] {
      op_up       = 3'd0,  // Count up by one.
      op_step     = 3'd1,  // Add the unsigned increment.
      op_step_neg = 3'd2,  // Subtract the increment.
      op_fill     = 3'd3   // Repeat the base value.
   } rng_op_e;

   // Command word as it arrives on the external stream, 43 bits.
   typedef struct packed {
      rng_op_e               op;
      logic [rng_data_w-1:0] base;
      logic [rng_data_w-1:0] incr;
      logic [rng_cnt_w-1:0]  cnt;   // Number of elements, zero is rejected.
   } rng_cmd_t;

   // Decoded generator configuration.
   typedef struct packed {
      logic [rng_data_w-1:0] base;
      logic [rng_data_w-1:0] step;  // Effective increment, two's complement.
      logic [rng_cnt_w-1:0]  cnt;
   } rng_cfg_t;

   // One element of the output stream.
   typedef struct packed {
      logic [rng_data_w-1:0] data;
      logic [rng_cnt_w-1:0]  idx;   // Position within the command.
      logic                  eot;   // Last element of the command.
   } rng_out_t;

endpackage

// ==== rng_result.sv ====
`timescale 1ns/100ps

module rng_result (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           el_valid,
   input  rng_pkg::rng_out_t              el,
   output logic                           el_ready,
   input  logic                           rej_pulse,
   output logic                           out_valid,
   output rng_pkg::rng_out_t              out,
   input  logic                           out_ready,
   output logic [rng_pkg::rng_stat_w-1:0] cmd_done_cnt,
   output logic [rng_pkg::rng_stat_w-1:0] cmd_rej_cnt
);

   logic load;
   logic pop;
   logic done;

   // Full throughput slice, refill in the same cycle as the drain.
   assign el_ready = ~out_valid | out_ready;
   assign load     = el_valid & el_ready;
   assign pop      = out_valid & out_ready;

   // A command completes when its last element leaves the port.
   assign done = pop & out.eot;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= 1'b1;
      end else if (pop) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         out <= el;  // Data, index tag and eot travel together.
      end
   end

   // Status counters.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_done_cnt <= '0;
         cmd_rej_cnt  <= '0;
      end else begin
         if (done) begin
            cmd_done_cnt <= cmd_done_cnt + 1'b1;
         end
         if (rej_pulse) begin
            cmd_rej_cnt <= cmd_rej_cnt + 1'b1;
         end
      end
   end

endmodule

// ==== rng_top.sv ====
`timescale 1ns/100ps

module rng_top (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           cmd_valid,
   input  rng_pkg::rng_cmd_t              cmd,
   output logic                           cmd_ready,
   output logic                           out_valid,
   output rng_pkg::rng_out_t              out,
   input  logic                           out_ready,
   output logic [rng_pkg::rng_stat_w-1:0] cmd_done_cnt,
   output logic [rng_pkg::rng_stat_w-1:0] cmd_rej_cnt
);

   // Decode to execute.
   logic              cfg_valid;
   logic              cfg_ready;
   rng_pkg::rng_cfg_t cfg;
   logic              rej_pulse;

   // Execute to result.
   logic              el_valid;
   logic              el_ready;
   rng_pkg::rng_out_t el;

   rng_decode u_decode (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .cmd_ready (cmd_ready),
      .cfg_valid (cfg_valid),
      .cfg       (cfg),
      .cfg_ready (cfg_ready),
      .rej_pulse (rej_pulse)
   );

   rng_gen u_gen (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_valid (cfg_valid),
      .cfg       (cfg),
      .cfg_ready (cfg_ready),
      .el_valid  (el_valid),
      .el        (el),
      .el_ready  (el_ready)
   );

   rng_result u_result (
      .clk          (clk),
      .rst_n        (rst_n),
      .el_valid     (el_valid),
      .el           (el),
      .el_ready     (el_ready),
      .rej_pulse    (rej_pulse),
      .out_valid    (out_valid),
      .out          (out),
      .out_ready    (out_ready),
      .cmd_done_cnt (cmd_done_cnt),
      .cmd_rej_cnt  (cmd_rej_cnt)
   );

endmodule

// ==== tb_rng_top.sv ====
`timescale 1ns/100ps

module tb_rng_top;

   localparam int n_tests = 14;
   localparam int n_full  = 4;   // Leading entries run without back-pressure.

   // One table row, the command fields plus the expected outcome.
   typedef struct packed {
      logic [2:0]                     op;
      logic [rng_pkg::rng_data_w-1:0] base;
      logic [rng_pkg::rng_data_w-1:0] incr;
      logic [rng_pkg::rng_cnt_w-1:0]  cnt;
      logic                           rej;
   } entry_t;

   // One element due on the output port.
   typedef struct packed {
      logic [rng_pkg::rng_data_w-1:0] data;
      logic [rng_pkg::rng_cnt_w-1:0]  idx;
      logic                           eot;
      logic [7:0]                     test;
   } elem_t;

   logic                                 clk;
   logic                                 rst_n;
   logic                                 cmd_valid;
   logic [$bits(rng_pkg::rng_cmd_t)-1:0] cmd_word;
   logic                                 cmd_ready;
   logic                                 out_valid;
   rng_pkg::rng_out_t                    out;
   logic                                 out_ready;
   logic [rng_pkg::rng_stat_w-1:0]       cmd_done_cnt;
   logic [rng_pkg::rng_stat_w-1:0]       cmd_rej_cnt;

   entry_t tbl [0:n_tests-1];
   elem_t  exp_q [$];
   int     test_err [0:n_tests-1];
   int     errors;
   int     elements;
   int     n_legal;
   int     n_rej;
   bit     aborted;
   bit     full_rate;
   bit     streaming;

   rng_top uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd_valid    (cmd_valid),
      .cmd          (cmd_word),
      .cmd_ready    (cmd_ready),
      .out_valid    (out_valid),
      .out          (out),
      .out_ready    (out_ready),
      .cmd_done_cnt (cmd_done_cnt),
      .cmd_rej_cnt  (cmd_rej_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Effective increment of each legal opcode.
   function automatic logic [15:0] step_for(input logic [2:0] op, input logic [15:0] incr);
      case (op)
         rng_pkg::op_up:       return 16'd1;
         rng_pkg::op_step:     return incr;
         rng_pkg::op_step_neg: return 16'd0 - incr;
         default:              return 16'd0;
      endcase
   endfunction

   task automatic load_table();
      // op, base, incr, cnt, expect reject.
      tbl[0]  = '{3'd0, 16'h0010, 16'h0005, 8'd5,  1'b0};
      tbl[1]  = '{3'd1, 16'h0100, 16'h0003, 8'd4,  1'b0};
      tbl[2]  = '{3'd2, 16'h0005, 16'h0002, 8'd6,  1'b0};  // Descends below zero.
      tbl[3]  = '{3'd3, 16'hbeef, 16'h1111, 8'd3,  1'b0};
      tbl[4]  = '{3'd0, 16'hfffd, 16'h0000, 8'd6,  1'b0};  // Wraps past 16 bits.
      tbl[5]  = '{3'd1, 16'hf000, 16'h0800, 8'd5,  1'b0};
      tbl[6]  = '{3'd5, 16'h0001, 16'h0001, 8'd4,  1'b1};  // Illegal opcode.
      tbl[7]  = '{3'd3, 16'h1234, 16'h0000, 8'd1,  1'b0};
      tbl[8]  = '{3'd0, 16'h0040, 16'h0000, 8'd0,  1'b1};  // Zero count.
      tbl[9]  = '{3'd2, 16'h8000, 16'h1000, 8'd7,  1'b0};
      tbl[10] = '{3'd7, 16'h0000, 16'h0002, 8'd2,  1'b1};
      tbl[11] = '{3'd1, 16'h0007, 16'hffff, 8'd20, 1'b0};
      tbl[12] = '{3'd0, 16'h0000, 16'h0000, 8'd64, 1'b0};
      tbl[13] = '{3'd2, 16'h0000, 16'h0001, 8'd1,  1'b0};
   endtask

   // Drive one command, wait for the handshake, then queue its elements.
   task automatic send_cmd(input int t);
      int          waits;
      int          i;
      bit          taken;
      logic [15:0] rej_before;
      logic [15:0] pos;
      elem_t       e;
      waits      = 0;
      taken      = 1'b0;
      rej_before = '0;
      cmd_word   = {tbl[t].op, tbl[t].base, tbl[t].incr, tbl[t].cnt};
      cmd_valid  = 1'b1;
      while (!taken && waits < 1000) begin
         @(negedge clk);
         if (cmd_ready) begin
            taken = 1'b1;
         end
         rej_before = cmd_rej_cnt;
         @(posedge clk);
         #10;
         waits++;
      end
      cmd_valid = 1'b0;
      if (!taken) begin
         $display("Timeout: test %0d was never accepted by the DUT", t);
         errors++;
         aborted = 1'b1;
      end else if (tbl[t].rej) begin
         waits = 0;
         while (cmd_rej_cnt == rej_before && waits < 10) begin
            @(negedge clk);
            waits++;
         end
         if (cmd_rej_cnt == rej_before) begin
            $display("Timeout: test %0d was not counted as rejected", t);
            errors++;
            test_err[t]++;
         end else begin
            repeat (2) @(negedge clk);  // A second pulse would show up here.
            if (cmd_rej_cnt !== rej_before + 16'd1) begin
               $display("ERROR %0t ns: cmd_rej_cnt expected %0h actual %0h",
                        $time, rej_before + 16'd1, cmd_rej_cnt);
               errors++;
               test_err[t]++;
            end
         end
         $display("Test %0d: rejected, %0d errors", t, test_err[t]);
         @(posedge clk);
         #10;
      end else begin
         for (i = 0; i < tbl[t].cnt; i++) begin
            pos    = i[15:0];
            e.data = tbl[t].base + step_for(tbl[t].op, tbl[t].incr) * pos;
            e.idx  = pos[7:0];
            e.eot  = (i == tbl[t].cnt - 1);
            e.test = t[7:0];
            exp_q.push_back(e);
         end
      end
   endtask

   // Output collector with random back-pressure.
   initial begin
      elem_t       e;
      logic [31:0] rnd;
      rnd       = 32'he60b;
      out_ready = 1'b0;
      streaming = 1'b0;
      forever begin
         @(posedge clk);
         #10;
         rnd       = next_random(rnd);
         out_ready = full_rate ? 1'b1 : (rnd[1:0] != 2'b00);
         @(negedge clk);
         // No drop out after a transfer within a command or between back-to-back legal commands.
         if (streaming && !out_valid && exp_q.size() != 0) begin
            e = exp_q[0];
            if (e.idx != '0 || (e.test != 0 && !tbl[e.test - 1].rej)) begin
               $display("Gap in the output stream at %0t ns while elements were still due",
                        $time);
               errors++;
            end
         end
         streaming = out_valid && out_ready;
         if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               $display("Unexpected element at %0t ns with no command pending", $time);
               errors++;
            end else begin
               e = exp_q.pop_front();
               elements++;
               if (out.data !== e.data) begin
                  $display("ERROR %0t ns: out.data expected %0h actual %0h",
                           $time, e.data, out.data);
                  errors++;
                  test_err[e.test]++;
               end
               if (out.idx !== e.idx) begin
                  $display("ERROR %0t ns: out.idx expected %0h actual %0h",
                           $time, e.idx, out.idx);
                  errors++;
                  test_err[e.test]++;
               end
               if (out.eot !== e.eot) begin
                  $display("ERROR %0t ns: out.eot expected %0h actual %0h",
                           $time, e.eot, out.eot);
                  errors++;
                  test_err[e.test]++;
               end
               if (e.eot) begin
                  $display("Test %0d: %0d elements checked, %0d errors",
                           e.test, tbl[e.test].cnt, test_err[e.test]);
               end
            end
         end
      end
   end

   initial begin
      int t;
      int waits;
      rst_n     = 1'b0;
      cmd_valid = 1'b0;
      cmd_word  = '0;
      full_rate = 1'b1;
      aborted   = 1'b0;
      errors    = 0;
      elements  = 0;
      n_legal   = 0;
      n_rej     = 0;
      load_table();
      for (t = 0; t < n_tests; t++) begin
         test_err[t] = 0;
         if (tbl[t].rej) begin
            n_rej++;
         end else begin
            n_legal++;
         end
      end

      repeat (8) @(posedge clk);
      #10;
      rst_n = 1'b1;
      @(negedge clk);
      if (out_valid !== 1'b0) begin
         $display("ERROR %0t ns: out_valid expected 0 actual %0h", $time, out_valid);
         errors++;
      end
      if (cmd_ready !== 1'b1) begin
         $display("ERROR %0t ns: cmd_ready expected 1 actual %0h", $time, cmd_ready);
         errors++;
      end
      @(posedge clk);
      #10;

      for (t = 0; t < n_tests && !aborted; t++) begin
         if (t == n_full) begin
            full_rate <= 1'b0;  // Random out_ready from here on.
         end
         send_cmd(t);
      end

      waits = 0;
      while (!aborted && exp_q.size() != 0 && waits < 5000) begin
         @(posedge clk);
         waits++;
      end
      if (!aborted && exp_q.size() != 0) begin
         $display("Timeout: %0d expected elements never came out", exp_q.size());
         errors++;
      end
      repeat (4) @(posedge clk);
      #10;
      if (cmd_done_cnt !== n_legal) begin
         $display("ERROR %0t ns: cmd_done_cnt expected %0h actual %0h",
                  $time, n_legal, cmd_done_cnt);
         errors++;
      end
      if (cmd_rej_cnt !== n_rej) begin
         $display("ERROR %0t ns: cmd_rej_cnt expected %0h actual %0h",
                  $time, n_rej, cmd_rej_cnt);
         errors++;
      end

      $display("Tests %0d, legal %0d, rejected %0d, elements %0d, errors %0d",
               n_tests, n_legal, n_rej, elements, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
